// ==== hw/fma_fmt_pkg.sv ====
/* Half-precision format constants, internal datapath widths
   and the vector types shared by the FMA datapath */
package fma_fmt_pkg;

  // --------------------
  // Format
  // --------------------
  localparam int EXP_BITS  = 5;
  localparam int MAN_BITS  = 10;
  localparam int PREC_BITS = MAN_BITS + 1;   // Implicit bit included
  localparam int BIAS      = 15;
  localparam int SIGN_BIT  = EXP_BITS + MAN_BITS;

  // --------------------
  // Datapath widths
  // --------------------
  localparam int EXP_WIDTH       = EXP_BITS + 2;       // Room for sign and exponent growth
  localparam int SUM_WIDTH       = 3 * PREC_BITS + 4;  // Product, addend, guard and round
  localparam int LOWER_SUM_WIDTH = 2 * PREC_BITS + 3;  // Window searched for leading zeros
  localparam int SHAMT_WIDTH     = $clog2(SUM_WIDTH + 1);

  typedef logic [EXP_BITS+MAN_BITS:0]  fp_t;       // Sign, exponent, mantissa
  typedef logic signed [EXP_WIDTH-1:0] exp_int_t;  // Biased, may go negative
  typedef logic [PREC_BITS-1:0]        mant_t;     // Mantissa with implicit bit
  typedef logic [SUM_WIDTH-1:0]        sum_t;
  typedef logic [SHAMT_WIDTH-1:0]      shamt_t;
  typedef logic [5:0]                  fp_info_t;

  // Bit positions within fp_info_t
  localparam int INFO_ZERO       = 0;
  localparam int INFO_SUBNORMAL  = 1;
  localparam int INFO_NORMAL     = 2;
  localparam int INFO_INF        = 3;
  localparam int INFO_NAN        = 4;
  localparam int INFO_SIGNALLING = 5;

  localparam fp_t QNAN = 16'h7E00;  // Canonical quiet NaN

endpackage

// ==== hw/fma_op_pkg.sv ====
/* Operation and rounding mode encodings, status flag vector */
package fma_op_pkg;

  // Operation groups, op_mod flips the addend sign on top
  typedef enum logic [1:0] {
    FMADD  = 2'd0,  // a*b + c
    FNMSUB = 2'd1,  // -a*b + c
    ADD    = 2'd2,  // 1.0*b + c
    MUL    = 2'd3   // a*b + -0.0
  } fma_op_e;

  typedef enum logic [2:0] {
    RNE = 3'd0,  // Nearest, ties to even
    RTZ = 3'd1,
    RDN = 3'd2,  // Toward -inf
    RUP = 3'd3,  // Toward +inf
    RMM = 3'd4   // Nearest, ties away from zero
  } rnd_mode_e;

  typedef logic [3:0] status_t;

  // Flag positions within status_t
  localparam int STATUS_NV = 3;
  localparam int STATUS_OF = 2;
  localparam int STATUS_UF = 1;
  localparam int STATUS_NX = 0;

endpackage

// ==== hw/fma_operand_prep.sv ====
/* Operand classification and operation dependent adjustment */
module fma_operand_prep
  import fma_fmt_pkg::*, fma_op_pkg::*;
(
  input  fp_t      operand_a_i,
  input  fp_t      operand_b_i,
  input  fp_t      operand_c_i,
  input  fma_op_e  op_i,
  input  logic     op_mod_i,
  output fp_t      op_a_o,
  output fp_t      op_b_o,
  output fp_t      op_c_o,
  output fp_info_t info_a_o,
  output fp_info_t info_b_o,
  output fp_info_t info_c_o
);

  // Class of one operand from its exponent and mantissa fields
  function automatic fp_info_t classify(input fp_t x);
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    fp_info_t info;
    exp_zero = (x[MAN_BITS +: EXP_BITS] == '0);
    exp_ones = (x[MAN_BITS +: EXP_BITS] == '1);
    man_zero = (x[MAN_BITS-1:0] == '0);
    info                  = '0;
    info[INFO_ZERO]       = exp_zero & man_zero;
    info[INFO_SUBNORMAL]  = exp_zero & ~man_zero;
    info[INFO_NORMAL]     = ~exp_zero & ~exp_ones;
    info[INFO_INF]        = exp_ones & man_zero;
    info[INFO_NAN]        = exp_ones & ~man_zero;
    info[INFO_SIGNALLING] = exp_ones & ~man_zero & ~x[MAN_BITS-1];  // Quiet bit clear
    return info;
  endfunction

  always_comb begin : op_adjust
    op_a_o   = operand_a_i;
    op_b_o   = operand_b_i;
    op_c_o   = operand_c_i;
    info_a_o = classify(operand_a_i);
    info_b_o = classify(operand_b_i);
    info_c_o = classify(operand_c_i);

    op_c_o[SIGN_BIT] = operand_c_i[SIGN_BIT] ^ op_mod_i;  // Subtract variants

    case (op_i)
      FNMSUB: op_a_o[SIGN_BIT] = ~operand_a_i[SIGN_BIT];   // Negate the product
      ADD: begin
        // Multiplicand becomes +1.0
        op_a_o                = {1'b0, EXP_BITS'(BIAS), MAN_BITS'(0)};
        info_a_o              = '0;
        info_a_o[INFO_NORMAL] = 1'b1;
      end
      MUL: begin
        // Addend -0.0 keeps the product sign of an exact zero
        op_c_o              = {1'b1, EXP_BITS'(0), MAN_BITS'(0)};
        info_c_o            = '0;
        info_c_o[INFO_ZERO] = 1'b1;
      end
      default: ;  // FMADD untouched
    endcase
  end

endmodule

// ==== hw/fma_special_case.sv ====
/* Special operand detection, canonical special result and its flags */
module fma_special_case
  import fma_fmt_pkg::*, fma_op_pkg::*;
(
  input  fp_t      op_a_i,
  input  fp_t      op_b_i,
  input  fp_t      op_c_i,
  input  fp_info_t info_a_i,
  input  fp_info_t info_b_i,
  input  fp_info_t info_c_i,
  output logic     special_o,
  output fp_t      special_result_o,
  output status_t  special_status_o
);

  logic any_inf;
  logic any_nan;
  logic any_snan;
  logic prod_inf;
  logic prod_sign;
  logic eff_sub;

  assign any_inf   = info_a_i[INFO_INF] | info_b_i[INFO_INF] | info_c_i[INFO_INF];
  assign any_nan   = info_a_i[INFO_NAN] | info_b_i[INFO_NAN] | info_c_i[INFO_NAN];
  assign any_snan  = info_a_i[INFO_SIGNALLING] | info_b_i[INFO_SIGNALLING]
                   | info_c_i[INFO_SIGNALLING];
  assign prod_inf  = info_a_i[INFO_INF] | info_b_i[INFO_INF];
  assign prod_sign = op_a_i[SIGN_BIT] ^ op_b_i[SIGN_BIT];
  assign eff_sub   = prod_sign ^ op_c_i[SIGN_BIT];  // Product and addend signs differ

  always_comb begin : special_select
    special_o        = 1'b0;
    special_result_o = QNAN;
    special_status_o = '0;
    // inf*0 is invalid whatever the addend, quiet NaN included
    if ((info_a_i[INFO_INF] && info_b_i[INFO_ZERO]) ||
        (info_a_i[INFO_ZERO] && info_b_i[INFO_INF])) begin
      special_o                   = 1'b1;
      special_status_o[STATUS_NV] = 1'b1;
    end else if (any_nan) begin
      special_o                   = 1'b1;
      special_status_o[STATUS_NV] = any_snan;  // Only signalling NaNs raise NV
    end else if (any_inf) begin
      special_o = 1'b1;
      if (prod_inf && info_c_i[INFO_INF] && eff_sub) begin
        special_status_o[STATUS_NV] = 1'b1;    // inf - inf
      end else if (prod_inf) begin
        special_result_o = {prod_sign, {EXP_BITS{1'b1}}, MAN_BITS'(0)};
      end else begin
        special_result_o = {op_c_i[SIGN_BIT], {EXP_BITS{1'b1}}, MAN_BITS'(0)};
      end
    end
  end

endmodule

// ==== hw/fma_sum_path.sv ====
/* Exponent datapath, mantissa product, addend alignment
   and the wide signed-magnitude addition */
module fma_sum_path
  import fma_fmt_pkg::*;
(
  input  fp_t      op_a_i,
  input  fp_t      op_b_i,
  input  fp_t      op_c_i,
  input  fp_info_t info_a_i,
  input  fp_info_t info_b_i,
  input  fp_info_t info_c_i,
  output sum_t     sum_o,
  output logic     final_sign_o,
  output logic     eff_sub_o,
  output logic     sticky_o,
  output exp_int_t exp_product_o,
  output exp_int_t exp_diff_o,
  output exp_int_t tent_exp_o,
  output shamt_t   addend_shamt_o
);

  // Subnormals and zeros share the minimum exponent of 1
  function automatic exp_int_t adj_exp(input fp_t x);
    if (x[MAN_BITS +: EXP_BITS] == '0) return exp_int_t'(1);
    return exp_int_t'({2'b00, x[MAN_BITS +: EXP_BITS]});
  endfunction

  // --------------------
  // Exponents
  // --------------------
  exp_int_t exp_addend;
  logic     tent_sign;

  assign exp_addend    = adj_exp(op_c_i);
  assign exp_product_o = (info_a_i[INFO_ZERO] || info_b_i[INFO_ZERO])
                       ? exp_int_t'(2 - BIAS)  // Zero product sits at the bottom
                       : exp_int_t'(adj_exp(op_a_i) + adj_exp(op_b_i) - BIAS);
  assign exp_diff_o    = exp_addend - exp_product_o;
  assign tent_exp_o    = (exp_diff_o > 0) ? exp_addend : exp_product_o;
  assign tent_sign     = op_a_i[SIGN_BIT] ^ op_b_i[SIGN_BIT];
  assign eff_sub_o     = tent_sign ^ op_c_i[SIGN_BIT];

  always_comb begin : addend_shift_amount
    if (exp_diff_o <= -(2 * PREC_BITS + 1))
      addend_shamt_o = shamt_t'(SUM_WIDTH);  // Addend lands in sticky only
    else if (exp_diff_o <= PREC_BITS + 2)
      addend_shamt_o = shamt_t'(PREC_BITS + 3 - exp_diff_o);
    else
      addend_shamt_o = '0;                   // Addend anchored
  end

  // --------------------
  // Mantissas
  // --------------------
  mant_t                        mant_a;
  mant_t                        mant_b;
  mant_t                        mant_c;
  logic [2*PREC_BITS-1:0]       product;
  sum_t                         product_shifted;
  logic [SUM_WIDTH+PREC_BITS-1:0] addend_wide;  // Aligned addend plus shifted-out bits
  sum_t                         addend_shifted;
  logic                         inject_carry;
  logic [SUM_WIDTH:0]           sum_raw;        // Carry kept for the sign fix

  assign mant_a          = {info_a_i[INFO_NORMAL], op_a_i[MAN_BITS-1:0]};
  assign mant_b          = {info_b_i[INFO_NORMAL], op_b_i[MAN_BITS-1:0]};
  assign mant_c          = {info_c_i[INFO_NORMAL], op_c_i[MAN_BITS-1:0]};
  assign product         = mant_a * mant_b;
  assign product_shifted = sum_t'(product) << 2;  // Room for round and sticky

  assign addend_wide    = {mant_c, {SUM_WIDTH{1'b0}}} >> addend_shamt_o;
  assign sticky_o       = |addend_wide[PREC_BITS-1:0];
  assign addend_shifted = eff_sub_o ? ~addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS]
                                    : addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS];
  assign inject_carry   = eff_sub_o & ~sticky_o;  // Two's complement unless bits were lost

  assign sum_raw = product_shifted + addend_shifted + inject_carry;

  // No carry under subtraction means the addend was larger
  assign sum_o        = (eff_sub_o && !sum_raw[SUM_WIDTH]) ? -sum_raw[SUM_WIDTH-1:0]
                                                          : sum_raw[SUM_WIDTH-1:0];
  assign final_sign_o = eff_sub_o ? (sum_raw[SUM_WIDTH] == tent_sign) : tent_sign;

endmodule

// ==== hw/fma_stage_reg.sv ====
/* One-entry handshaked register between front end and back end */
module fma_stage_reg
  import fma_fmt_pkg::*, fma_op_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  input  sum_t      sum_i,
  input  logic      final_sign_i,
  input  logic      eff_sub_i,
  input  logic      sticky_i,
  input  exp_int_t  exp_product_i,
  input  exp_int_t  exp_diff_i,
  input  exp_int_t  tent_exp_i,
  input  shamt_t    addend_shamt_i,
  input  logic      special_i,
  input  fp_t       special_result_i,
  input  status_t   special_status_i,
  input  rnd_mode_e rnd_mode_i,
  output sum_t      sum_o,
  output logic      final_sign_o,
  output logic      eff_sub_o,
  output logic      sticky_o,
  output exp_int_t  exp_product_o,
  output exp_int_t  exp_diff_o,
  output exp_int_t  tent_exp_o,
  output shamt_t    addend_shamt_o,
  output logic      special_o,
  output fp_t       special_result_o,
  output status_t   special_status_o,
  output rnd_mode_e rnd_mode_o
);

  // Free when empty or drained this cycle
  assign in_ready_o = ~out_valid_o | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i)
      out_valid_o <= 1'b0;
    else if (in_ready_o)
      out_valid_o <= in_valid_i;
  end

  // Payload moves only on an input transfer
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      sum_o            <= sum_i;
      final_sign_o     <= final_sign_i;
      eff_sub_o        <= eff_sub_i;
      sticky_o         <= sticky_i;
      exp_product_o    <= exp_product_i;
      exp_diff_o       <= exp_diff_i;
      tent_exp_o       <= tent_exp_i;
      addend_shamt_o   <= addend_shamt_i;
      special_o        <= special_i;
      special_result_o <= special_result_i;
      special_status_o <= special_status_i;
      rnd_mode_o       <= rnd_mode_i;
    end
  end

endmodule

// ==== hw/fma_norm_round.sv ====
/* Normalization, rounding, flag generation, special result
   selection and the handshaked output register */
module fma_norm_round
  import fma_fmt_pkg::*, fma_op_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  sum_t      sum_i,
  input  logic      final_sign_i,
  input  logic      eff_sub_i,
  input  logic      sticky_i,
  input  exp_int_t  exp_product_i,
  input  exp_int_t  exp_diff_i,
  input  exp_int_t  tent_exp_i,
  input  shamt_t    addend_shamt_i,
  input  logic      special_i,
  input  fp_t       special_result_i,
  input  status_t   special_status_i,
  input  rnd_mode_e rnd_mode_i,
  output fp_t       result_o,
  output status_t   status_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  // Leading zeros in the lower sum window
  function automatic shamt_t lzc(input logic [LOWER_SUM_WIDTH-1:0] v);
    shamt_t cnt;
    cnt = shamt_t'(LOWER_SUM_WIDTH);
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (v[i]) cnt = shamt_t'(LOWER_SUM_WIDTH - 1 - i);  // Highest set bit wins
    end
    return cnt;
  endfunction

  // --------------------
  // Normalization
  // --------------------
  shamt_t                 lz_cnt;
  exp_int_t               lz_exp;
  logic                   lz_empty;
  shamt_t                 norm_shamt;
  exp_int_t               norm_exp;
  logic [SUM_WIDTH:0]     sum_shifted;
  logic [PREC_BITS:0]     final_mant;   // Mantissa plus round bit
  logic [LOWER_SUM_WIDTH-1:0] sum_sticky;
  exp_int_t               final_exp;
  logic                   sticky_norm;

  assign lz_cnt   = lzc(sum_i[LOWER_SUM_WIDTH-1:0]);
  assign lz_exp   = exp_int_t'(lz_cnt);
  assign lz_empty = (sum_i[LOWER_SUM_WIDTH-1:0] == '0);

  always_comb begin : norm_shift_amount
    // Product anchored or heavy cancellation
    if ((exp_diff_i <= 0) || (eff_sub_i && (exp_diff_i <= 2))) begin
      if ((exp_product_i - lz_exp + 1 >= 0) && !lz_empty) begin
        norm_shamt = shamt_t'(PREC_BITS + 2) + lz_cnt;
        norm_exp   = exp_product_i - lz_exp + 1;
      end else begin
        norm_shamt = shamt_t'(exp_product_i + PREC_BITS + 2);  // Capped at the subnormal range
        norm_exp   = '0;
      end
    end else begin
      norm_shamt = addend_shamt_i;  // Addend anchored, undo alignment
      norm_exp   = tent_exp_i;
    end
  end

  assign sum_shifted = {1'b0, sum_i} << norm_shamt;

  // One-bit fix-up, the leading one may sit either side of the MSB
  always_comb begin : small_norm
    {final_mant, sum_sticky} = sum_shifted[SUM_WIDTH-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      {final_mant, sum_sticky} = sum_shifted[SUM_WIDTH:1];
      final_exp                = norm_exp + 1;
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      final_exp = norm_exp;                  // Already normalized
    end else if (norm_exp > 1) begin
      {final_mant, sum_sticky} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exp                = norm_exp - 1;
    end else begin
      final_exp = '0;                        // Subnormal result
    end
  end

  assign sticky_norm = (|sum_sticky) | sticky_i;

  // --------------------
  // Rounding
  // --------------------
  logic                         of_before;
  logic [EXP_BITS+MAN_BITS-1:0] pre_round_abs;
  logic [EXP_BITS+MAN_BITS-1:0] rounded_abs;
  logic [1:0]                   rs_bits;      // Round and sticky
  logic                         round_up;
  logic                         exact_zero;
  logic                         rounded_sign;
  logic                         of_after;
  logic                         uf_after;
  fp_t                          regular_result;
  status_t                      regular_status;

  assign of_before     = final_exp >= exp_int_t'((1 << EXP_BITS) - 1);
  // Overflow starts from the largest finite value with R and S forced
  assign pre_round_abs = of_before ? {EXP_BITS'((1 << EXP_BITS) - 2), {MAN_BITS{1'b1}}}
                                   : {final_exp[EXP_BITS-1:0], final_mant[MAN_BITS:1]};
  assign rs_bits       = {final_mant[0] | of_before, sticky_norm | of_before};

  always_comb begin : round_decision
    case (rnd_mode_i)
      RNE:     round_up = rs_bits[1] & (rs_bits[0] | pre_round_abs[0]);  // Ties to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs_bits) & final_sign_i;
      RUP:     round_up = (|rs_bits) & ~final_sign_i;
      RMM:     round_up = rs_bits[1];
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs  = pre_round_abs + round_up;
  assign exact_zero   = (pre_round_abs == '0) && (rs_bits == '0);
  // Exact zero from cancellation is -0 only toward -inf
  assign rounded_sign = (exact_zero && eff_sub_i) ? (rnd_mode_i == RDN) : final_sign_i;

  assign of_after       = rounded_abs[MAN_BITS +: EXP_BITS] == '1;
  assign uf_after       = rounded_abs[MAN_BITS +: EXP_BITS] == '0;
  assign regular_result = {rounded_sign, rounded_abs};

  always_comb begin : regular_flags
    regular_status            = '0;
    regular_status[STATUS_OF] = of_before | of_after;
    regular_status[STATUS_NX] = (|rs_bits) | of_before | of_after;
    regular_status[STATUS_UF] = uf_after & regular_status[STATUS_NX];  // Tiny and inexact
  end

  // --------------------
  // Output register
  // --------------------
  assign in_ready_o = ~out_valid_o | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i)
      out_valid_o <= 1'b0;
    else if (in_ready_o)
      out_valid_o <= in_valid_i;
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      result_o <= special_i ? special_result_i : regular_result;
      status_o <= special_i ? special_status_i : regular_status;
    end
  end

endmodule

// ==== hw/fma_unit.sv ====
/* Half-precision FMA top level, front end, stage register and back end */
module fma_unit
  import fma_fmt_pkg::*, fma_op_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  fp_t       operand_a_i,
  input  fp_t       operand_b_i,
  input  fp_t       operand_c_i,
  input  fma_op_e   op_i,
  input  logic      op_mod_i,
  input  rnd_mode_e rnd_mode_i,
  output fp_t       result_o,
  output status_t   status_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  // Front end
  fp_t      op_a, op_b, op_c;
  fp_info_t info_a, info_b, info_c;
  logic     special;
  fp_t      special_result;
  status_t  special_status;
  sum_t     sum;
  logic     final_sign, eff_sub, sticky;
  exp_int_t exp_product, exp_diff, tent_exp;
  shamt_t   addend_shamt;

  // Stage register outputs
  logic      stage_valid, back_ready;
  sum_t      sum_q;
  logic      final_sign_q, eff_sub_q, sticky_q, special_q;
  exp_int_t  exp_product_q, exp_diff_q, tent_exp_q;
  shamt_t    addend_shamt_q;
  fp_t       special_result_q;
  status_t   special_status_q;
  rnd_mode_e rnd_mode_q;

  fma_operand_prep u_prep (
    .operand_a_i, .operand_b_i, .operand_c_i, .op_i, .op_mod_i,
    .op_a_o   (op_a),
    .op_b_o   (op_b),
    .op_c_o   (op_c),
    .info_a_o (info_a),
    .info_b_o (info_b),
    .info_c_o (info_c)
  );

  fma_special_case u_special (
    .op_a_i           (op_a),
    .op_b_i           (op_b),
    .op_c_i           (op_c),
    .info_a_i         (info_a),
    .info_b_i         (info_b),
    .info_c_i         (info_c),
    .special_o        (special),
    .special_result_o (special_result),
    .special_status_o (special_status)
  );

  fma_sum_path u_sum (
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .op_c_i         (op_c),
    .info_a_i       (info_a),
    .info_b_i       (info_b),
    .info_c_i       (info_c),
    .sum_o          (sum),
    .final_sign_o   (final_sign),
    .eff_sub_o      (eff_sub),
    .sticky_o       (sticky),
    .exp_product_o  (exp_product),
    .exp_diff_o     (exp_diff),
    .tent_exp_o     (tent_exp),
    .addend_shamt_o (addend_shamt)
  );

  fma_stage_reg u_stage (
    .clk_i, .rst_n_i, .in_valid_i, .in_ready_o, .rnd_mode_i,
    .out_valid_o      (stage_valid),
    .out_ready_i      (back_ready),
    .sum_i            (sum),
    .final_sign_i     (final_sign),
    .eff_sub_i        (eff_sub),
    .sticky_i         (sticky),
    .exp_product_i    (exp_product),
    .exp_diff_i       (exp_diff),
    .tent_exp_i       (tent_exp),
    .addend_shamt_i   (addend_shamt),
    .special_i        (special),
    .special_result_i (special_result),
    .special_status_i (special_status),
    .sum_o            (sum_q),
    .final_sign_o     (final_sign_q),
    .eff_sub_o        (eff_sub_q),
    .sticky_o         (sticky_q),
    .exp_product_o    (exp_product_q),
    .exp_diff_o       (exp_diff_q),
    .tent_exp_o       (tent_exp_q),
    .addend_shamt_o   (addend_shamt_q),
    .special_o        (special_q),
    .special_result_o (special_result_q),
    .special_status_o (special_status_q),
    .rnd_mode_o       (rnd_mode_q)
  );

  fma_norm_round u_back (
    .clk_i, .rst_n_i, .result_o, .status_o, .out_valid_o, .out_ready_i,
    .in_valid_i       (stage_valid),
    .in_ready_o       (back_ready),
    .sum_i            (sum_q),
    .final_sign_i     (final_sign_q),
    .eff_sub_i        (eff_sub_q),
    .sticky_i         (sticky_q),
    .exp_product_i    (exp_product_q),
    .exp_diff_i       (exp_diff_q),
    .tent_exp_i       (tent_exp_q),
    .addend_shamt_i   (addend_shamt_q),
    .special_i        (special_q),
    .special_result_i (special_result_q),
    .special_status_i (special_status_q),
    .rnd_mode_i       (rnd_mode_q)
  );

endmodule

// ==== verif/fma_unit_props.sv ====
/* Bound checks on the FMA unit, results against the expected queue head,
   output hold under stall, idle state after reset and two-cycle latency */
module fma_unit_props
  import fma_fmt_pkg::*, fma_op_pkg::*;
(
  input logic    clk_i,
  input logic    rst_n_i,
  input logic    in_valid_i,
  input logic    in_ready_i,
  input logic    out_valid_i,
  input logic    out_ready_i,
  input fp_t     result_i,
  input status_t status_i,
  input logic    exp_valid_i,
  input fp_t     exp_result_i,
  input status_t exp_status_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // Read by the testbench at the end

  // --------------------
  // Reset
  // --------------------
  reset_valid_a: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i)
    else begin
      fail_cnt++;
      $error("ERROR out_valid_o is 0x%h after reset, expected 0x0", out_valid_i);
    end

  reset_ready_a: assert property (@(posedge clk_i) !rst_n_i |=> in_ready_i)
    else begin
      fail_cnt++;
      $error("ERROR in_ready_o is 0x%h after reset, expected 0x1", in_ready_i);
    end

  // --------------------
  // Results
  // --------------------
  no_extra_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && out_ready_i |-> exp_valid_i)
    else begin
      fail_cnt++;
      $error("The DUT delivered a result with no operation pending");
    end

  result_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && out_ready_i && exp_valid_i |-> result_i == exp_result_i)
    else begin
      fail_cnt++;
      $error("ERROR result_o got 0x%h expected 0x%h", result_i, exp_result_i);
    end

  status_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && out_ready_i && exp_valid_i |-> status_i == exp_status_i)
    else begin
      fail_cnt++;
      $error("ERROR status_o got 0x%h expected 0x%h", status_i, exp_status_i);
    end

  // --------------------
  // Handshake
  // --------------------
  stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(result_i) && $stable(status_i))
    else begin
      fail_cnt++;
      $error("ERROR output changed under stall, result_o 0x%h status_o 0x%h",
             result_i, status_i);
    end

  // Accepted input with a free path ahead shows up two edges later
  latency_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(in_valid_i && in_ready_i) && out_ready_i |=> out_valid_i)
    else begin
      fail_cnt++;
      $error("A result did not arrive two cycles after its input was accepted");
    end

endmodule

// ==== verif/tb_fma_unit.sv ====
/* FMA unit testbench with clock, reset, directed and random stimulus,
   expected result queue for the bound checks, watchdog and closing report */
module tb_fma_unit
  import fma_fmt_pkg::*, fma_op_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_RANDOM     = 60;
  localparam int RESET_CYCLES = 8;
  localparam int CLK_PERIOD   = 4;

  typedef logic [53:0] stim_t;  // a, b, c, op, op_mod, rounding mode
  typedef logic [19:0] expect_t;  // Result and status

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  logic      in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  fp_t       operand_a_i, operand_b_i, operand_c_i, result_o;
  fma_op_e   op_i;
  logic      op_mod_i;
  rnd_mode_e rnd_mode_i;
  status_t   status_o;

  stim_t       stim_q[$];
  expect_t     exp_q[$];    // Expected result of every operation, in issue order
  expect_t     pend_q[$];   // Expected results of accepted operations still in flight
  logic        exp_valid;   // Head of the in-flight queue, seen by the props
  fp_t         exp_result;
  status_t     exp_status;
  int unsigned lcg_state = 19;
  int unsigned timeouts  = 0;
  int          n_ops     = 0;
  logic        built     = 1'b0;

  fma_unit i_dut (.*);

  bind fma_unit fma_unit_props u_props (
    .clk_i, .rst_n_i, .in_valid_i, .out_ready_i,
    .in_ready_i   (in_ready_o),
    .out_valid_i  (out_valid_o),
    .result_i     (result_o),
    .status_i     (status_o),
    .exp_valid_i  (tb_fma_unit.exp_valid),
    .exp_result_i (tb_fma_unit.exp_result),
    .exp_status_i (tb_fma_unit.exp_status)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;  // Low bits of an LCG cycle too fast
  endfunction

  function automatic status_t flags(input logic nv, input logic of, input logic uf,
                                    input logic nx);
    status_t s;
    s            = '0;
    s[STATUS_NV] = nv;
    s[STATUS_OF] = of;
    s[STATUS_UF] = uf;
    s[STATUS_NX] = nx;
    return s;
  endfunction

  // Exact encoding of an integer below 2048 in magnitude, zero as +0
  function automatic fp_t encode_int(input int v);
    int   mag;
    int   msb;
    logic sgn;
    if (v == 0) return 16'h0000;
    sgn = (v < 0);
    mag = sgn ? -v : v;
    msb = 0;
    for (int i = 0; i < 11; i++) begin
      if (mag[i]) msb = i;
    end
    return {sgn, 5'(msb + 15), 10'(mag << (10 - msb))};  // Leading one drops out
  endfunction

  // Exact cancellation gives -0 only when rounding down
  function automatic fp_t zero_of(input rnd_mode_e rm);
    return (rm == RDN) ? 16'h8000 : 16'h0000;
  endfunction

  task automatic add_op(input fp_t a, input fp_t b, input fp_t c, input fma_op_e op,
                        input logic mod, input rnd_mode_e rm, input fp_t res,
                        input status_t st);
    stim_q.push_back({a, b, c, op, mod, rm});
    exp_q.push_back({res, st});
  endtask

  task automatic build_directed_ops();
    rnd_mode_e rm;
    add_op(16'h7C00, 16'h0000, 16'h3C00, FMADD, 1'b0, RNE, 16'h7E00,
           flags(1'b1, 1'b0, 1'b0, 1'b0));  // inf*0
    add_op(16'h7D00, 16'h3C00, 16'h0000, FMADD, 1'b0, RNE, 16'h7E00,
           flags(1'b1, 1'b0, 1'b0, 1'b0));  // Signalling NaN
    add_op(16'h3C00, 16'h3C00, 16'h7E00, FMADD, 1'b0, RTZ, 16'h7E00, '0);
    add_op(16'h7C00, 16'h3C00, 16'hFC00, FMADD, 1'b0, RNE, 16'h7E00,
           flags(1'b1, 1'b0, 1'b0, 1'b0));  // inf - inf
    add_op(16'h7C00, 16'h4000, 16'h3C00, FMADD, 1'b0, RUP, 16'h7C00, '0);
    for (int m = 0; m < 5; m++) begin
      rm = rnd_mode_e'(m);
      // Largest finite times 2, nearest and upward modes go to inf
      add_op(16'h7BFF, 16'h4000, 16'h0000, MUL, 1'b0, rm,
             (rm == RNE || rm == RUP || rm == RMM) ? 16'h7C00 : 16'h7BFF,
             flags(1'b0, 1'b1, 1'b0, 1'b1));
      add_op(16'h0000, 16'h4A40, 16'hCA40, ADD, 1'b0, rm, zero_of(rm), '0);
      // 1.0 + 2^-11 sits exactly halfway between 1.0 and its successor
      add_op(16'h0000, 16'h3C00, 16'h1000, ADD, 1'b0, rm,
             (rm == RUP || rm == RMM) ? 16'h3C01 : 16'h3C00,
             flags(1'b0, 1'b0, 1'b0, 1'b1));
    end
  endtask

  task automatic build_integer_ops();
    int        a, b, c, cs, r;
    fma_op_e   op;
    logic      mod;
    rnd_mode_e rm;
    for (int i = 0; i < N_RANDOM; i++) begin
      op  = fma_op_e'(next_rand() % 4);
      mod = 1'(next_rand() % 2);
      rm  = rnd_mode_e'(next_rand() % 5);
      a   = 1 + next_rand() % 31;    // Nonzero factors, zero results only by cancellation
      b   = 1 + next_rand() % 31;
      c   = next_rand() % 1024;
      if (next_rand() % 2 != 0) a = -a;
      if (next_rand() % 2 != 0) b = -b;
      if (next_rand() % 2 != 0) c = -c;
      cs = mod ? -c : c;
      case (op)
        FMADD:   r = a * b + cs;
        FNMSUB:  r = -(a * b) + cs;
        ADD:     r = b + cs;         // Multiplicand is 1.0
        default: r = a * b;          // MUL ignores the addend
      endcase
      add_op(encode_int(a), encode_int(b), encode_int(c), op, mod, rm,
             (r == 0) ? zero_of(rm) : encode_int(r), '0);
    end
  endtask

  task automatic show_head();
    exp_valid = (pend_q.size() > 0);
    if (exp_valid) {exp_result, exp_status} = pend_q[0];
  endtask

  task automatic drive_input(input int idx);
    stim_t s;
    if (idx < n_ops) begin
      s          = stim_q[idx];
      in_valid_i = 1'b1;
      {operand_a_i, operand_b_i, operand_c_i} = s[53:6];
      op_i       = fma_op_e'(s[5:4]);
      op_mod_i   = s[3];
      rnd_mode_i = rnd_mode_e'(s[2:0]);
    end else begin
      in_valid_i = 1'b0;
    end
  endtask

  task automatic finish_run();
    int unsigned fails;
    fails = i_dut.u_props.fail_cnt;
    $display("Closing report: %0d assertion failures, %0d timeouts", fails, timeouts);
    if (fails == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // --------------------
  // Stimulus and drain
  // --------------------
  initial begin : main
    int   in_idx;
    int   out_cnt;
    logic in_xfer, out_xfer;
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    op_i        = FMADD;
    op_mod_i    = 1'b0;
    rnd_mode_i  = RNE;
    out_ready_i = 1'b0;
    in_idx      = 0;
    out_cnt     = 0;
    build_directed_ops();
    build_integer_ops();
    n_ops = stim_q.size();
    built = 1'b1;
    show_head();
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_n_i     = 1'b1;
    out_ready_i = 1'b1;
    drive_input(in_idx);
    while (out_cnt < n_ops) begin
      @(negedge clk_i);
      in_xfer  = in_valid_i & in_ready_o;   // Both sides settled before the edge
      out_xfer = out_valid_o & out_ready_i;
      @(posedge clk_i);
      #1;
      if (out_xfer) begin
        if (pend_q.size() > 0) pend_q.delete(0);
        out_cnt++;
      end
      if (in_xfer) begin
        pend_q.push_back(exp_q[in_idx]);
        in_idx++;
      end
      show_head();
      drive_input(in_idx);
      out_ready_i = (next_rand() % 4 != 0);  // Stall roughly one cycle in four
    end
    // Idle cycles in which no further result may appear
    out_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    finish_run();
  end

  initial begin : watchdog
    wait (built);
    #(RESET_CYCLES * CLK_PERIOD + n_ops * 20 * CLK_PERIOD);
    $display("Timeout: the DUT did not return all %0d results in time", n_ops);
    timeouts++;
    finish_run();
  end

endmodule

// ==== fma_unit.f ====
hw/fma_fmt_pkg.sv
hw/fma_op_pkg.sv
hw/fma_operand_prep.sv
hw/fma_special_case.sv
hw/fma_sum_path.sv
hw/fma_stage_reg.sv
hw/fma_norm_round.sv
hw/fma_unit.sv
verif/fma_unit_props.sv
verif/tb_fma_unit.sv

// ==== Makefile ====
# Verilator build and run of the half-precision FMA testbench
TOP := tb_fma_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f fma_unit.f --Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
